// ==== tests/dbus_input.txt ====
// group port kind addr wdata wstrb expect, all hex
// kind 0 write, 1 read and compare, 2 read and keep, 3 read above kept, 4 read equal kept
// full word write and read back, on both ports
00000000 0 0 10000000 cafef00d f 00000000
00000001 0 1 10000000 00000000 0 cafef00d
00000002 1 0 10000004 12345678 f 00000000
00000003 1 1 10000004 00000000 0 12345678
00000004 1 1 10000000 00000000 0 cafef00d
00000005 0 1 10000004 00000000 0 12345678
// byte strobes on word 2
00000006 0 0 10000008 11223344 f 00000000
00000007 1 0 10000008 aabbccdd 5 00000000
00000008 0 1 10000008 00000000 0 11bb33dd
00000009 0 0 10000008 99000000 8 00000000
0000000a 1 1 10000008 00000000 0 99bb33dd
// both ports write at once, then cross read
0000000b 0 0 10000100 a5a5a5a5 f 00000000
0000000b 1 0 10000104 5a5a5a5a f 00000000
0000000c 0 1 10000104 00000000 0 5a5a5a5a
0000000c 1 1 10000100 00000000 0 a5a5a5a5
0000000d 0 0 10000200 0000beef 3 00000000
0000000d 1 0 10000204 feed0000 c 00000000
0000000e 0 1 10000204 00000000 0 feed0000
0000000e 1 1 10000200 00000000 0 0000beef
// unmapped write whose index field aliases word 4
0000000f 0 0 10000010 0badc0de f 00000000
00000010 1 0 20000010 deadbeef f 00000000
00000011 0 1 20000010 00000000 0 00000000
00000012 1 1 10000010 00000000 0 0badc0de
00000013 0 1 40001000 00000000 0 00000000
// counter clear, both halves zero
00000014 0 0 40000000 00000000 f 00000000
00000015 0 1 40000000 00000000 0 00000000
00000015 1 1 40000004 00000000 0 00000000
// counter run, low half grows
00000016 1 0 40000000 00000001 f 00000000
00000017 0 2 40000004 00000000 0 00000000
00000018 0 3 40000004 00000000 0 00000000
// counter hold with code 2 and code 3
00000019 1 0 40000000 00000002 f 00000000
0000001a 1 2 40000004 00000000 0 00000000
0000001b 1 4 40000004 00000000 0 00000000
0000001c 0 0 40000000 00000003 f 00000000
0000001d 0 2 40000004 00000000 0 00000000
0000001e 0 4 40000004 00000000 0 00000000
0000001f 1 1 40000000 00000000 0 00000000
ffffffff 0 0 00000000 00000000 0 00000000

// ==== verilog.f ====
common/dbus_pkg.sv
logic/dmem_ram.sv
logic/perf_counter.sv
dbus/dbus_port.sv
dbus/dbus_arbiter.sv
dbus/dbus_top.sv
tests/tb_dbus.sv

// ==== Makefile ====
# Verilator build and run of the data bus testbench

VERILATOR ?= verilator
TOP       ?= tb_dbus
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_dbus.sv ====
//////////////////////////////
// testbench for the two-port data bus, runs the
// transaction list in tests/dbus_input.txt
//////////////////////////////

`timescale 1ns/100ps

module tb_dbus;

    localparam int cols         = 7;    // words per line of the input file
    localparam int max_lines    = 64;
    localparam int ack_timeout  = 100;  // cycles from req to ack
    localparam int fall_timeout = 10;   // cycles from req drop to ack drop
    localparam int min_latency  = 4;
    localparam logic [31:0] end_mark = 32'hffff_ffff;

    // transaction kinds in the input file
    localparam logic [31:0] kind_write = 32'd0;
    localparam logic [31:0] kind_read  = 32'd1;  // compare with expect column
    localparam logic [31:0] kind_keep  = 32'd2;  // remember the value
    localparam logic [31:0] kind_above = 32'd3;  // must exceed remembered value
    localparam logic [31:0] kind_same  = 32'd4;  // must equal remembered value

    logic                          clk;
    logic                          rst_n;
    logic                          req_drv [dbus_pkg::n_ports];
    logic                          we_drv  [dbus_pkg::n_ports];
    logic [dbus_pkg::n_ports-1:0]  req;
    logic [dbus_pkg::n_ports-1:0]  we;
    logic [dbus_pkg::addr_w-1:0]   addr  [dbus_pkg::n_ports];
    logic [dbus_pkg::data_w-1:0]   wdata [dbus_pkg::n_ports];
    logic [dbus_pkg::strb_w-1:0]   wstrb [dbus_pkg::n_ports];
    logic [dbus_pkg::n_ports-1:0]  ack;
    logic [dbus_pkg::data_w-1:0]   rdata [dbus_pkg::n_ports];

    logic [31:0] stim [cols*max_lines];
    logic [31:0] kept [dbus_pkg::n_ports];  // per-port counter sample
    logic [31:0] lcg_state;
    int          errors;
    int          timeouts;
    int          checks;

    // each port process drives its own element
    for (genvar p = 0; p < dbus_pkg::n_ports; p++) begin : g_pack
        assign req[p] = req_drv[p];
        assign we[p]  = we_drv[p];
    end

    dbus_top dut_i (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .wstrb_i (wstrb),
        .ack_o   (ack),
        .rdata_o (rdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // one cycle on, just past the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // no request is out, so every ack must stay low
    task automatic idle_gap();
        logic [31:0] r;
        int          n;
        r = next_rand();
        n = int'(r[21:20]);  // 0 to 3 idle cycles
        for (int i = 0; i < n; i++) begin
            step();
            for (int p = 0; p < dbus_pkg::n_ports; p++) begin
                if (ack[p]) begin
                    errors++;
                    $display("port %0d: ack_o is high with no request", p);
                end
            end
        end
    endtask

    task automatic report_mismatch(input int p, input string rule,
                                   input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("[ERROR] %0t ns rdata_o[%0d] got %h expected %s%h", $time, p, got, rule, exp);
    endtask

    task automatic run_transfer(input int p, input int li);
        logic [31:0] kind;
        logic [31:0] exp;
        logic [31:0] got;
        int          cycles;
        kind = stim[li*cols+2];
        exp  = stim[li*cols+6];
        if (ack[p]) begin
            errors++;
            $display("port %0d: ack_o is already high before request at line %0d", p, li);
        end
        we_drv[p]  = (kind == kind_write);
        addr[p]    = stim[li*cols+3];
        wdata[p]   = stim[li*cols+4];
        wstrb[p]   = stim[li*cols+5][3:0];
        req_drv[p] = 1'b1;
        cycles = 0;
        while (!ack[p] && cycles < ack_timeout) begin
            step();
            cycles++;
        end
        if (!ack[p]) begin
            timeouts++;
            $display("port %0d: no ack within %0d cycles for line %0d", p, ack_timeout, li);
            req_drv[p] = 1'b0;
            return;
        end
        if (cycles < min_latency) begin
            errors++;
            $display("[ERROR] %0t ns ack_o[%0d] latency got %0d expected at least %0d",
                     $time, p, cycles, min_latency);
        end
        got = rdata[p];
        req_drv[p] = 1'b0;
        addr[p]    = next_rand();  // fields are free once ack is up
        wdata[p]   = next_rand();
        cycles = 0;
        while (ack[p] && cycles < fall_timeout) begin
            step();
            cycles++;
        end
        if (ack[p]) begin
            timeouts++;
            $display("port %0d: ack_o stayed high %0d cycles after req_i dropped", p, cycles);
        end else if (cycles != 1) begin
            errors++;
            $display("[ERROR] %0t ns ack_o[%0d] fall delay got %0d expected %0d",
                     $time, p, cycles, 1);
        end
        case (kind)
            kind_read: begin
                checks++;
                if (got !== exp) report_mismatch(p, "", got, exp);
            end
            kind_keep: kept[p] = got;
            kind_above: begin
                checks++;
                if (!(got > kept[p])) report_mismatch(p, "above ", got, kept[p]);
            end
            kind_same: begin
                checks++;
                if (got !== kept[p]) report_mismatch(p, "", got, kept[p]);
            end
            default: ;
        endcase
    endtask

    initial begin
        int          li;
        int          slot [dbus_pkg::n_ports];
        logic [31:0] grp;
        logic [31:0] port;
        rst_n     = 1'b0;
        lcg_state = 32'd89404;
        errors    = 0;
        timeouts  = 0;
        checks    = 0;
        for (int p = 0; p < dbus_pkg::n_ports; p++) begin
            req_drv[p] = 1'b0;
            we_drv[p]  = 1'b0;
            addr[p]    = '0;
            wdata[p]   = '0;
            wstrb[p]   = '0;
            kept[p]    = '0;
        end
        $readmemh("tests/dbus_input.txt", stim);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step();
        li = 0;
        while (li < max_lines && stim[li*cols] != end_mark) begin
            grp = stim[li*cols];
            for (int p = 0; p < dbus_pkg::n_ports; p++) slot[p] = -1;
            // lines of one group go out together
            while (li < max_lines && stim[li*cols] == grp) begin
                port = stim[li*cols+1];
                if (port >= dbus_pkg::n_ports || slot[int'(port)] != -1) begin
                    errors++;
                    $display("line %0d of the input file has a bad or repeated port", li);
                end else begin
                    slot[int'(port)] = li;
                end
                li++;
            end
            fork
                begin
                    if (slot[0] >= 0) run_transfer(0, slot[0]);
                end
                begin
                    if (slot[1] >= 0) run_transfer(1, slot[1]);
                end
            join
            idle_gap();
        end
        if (checks == 0) begin
            errors++;
            $display("no read checks were found in the input file");
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== dbus/dbus_top.sv ====
//////////////////////////////
// two-port data bus top: ports, arbiter,
// data memory and cycle counter
//////////////////////////////

`timescale 1ns/100ps

module dbus_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [dbus_pkg::n_ports-1:0]     req_i,
    input  logic [dbus_pkg::n_ports-1:0]     we_i,
    input  logic [dbus_pkg::addr_w-1:0]      addr_i [dbus_pkg::n_ports],
    input  logic [dbus_pkg::data_w-1:0]      wdata_i [dbus_pkg::n_ports],
    input  logic [dbus_pkg::strb_w-1:0]      wstrb_i [dbus_pkg::n_ports],
    output logic [dbus_pkg::n_ports-1:0]     ack_o,
    output logic [dbus_pkg::data_w-1:0]      rdata_o [dbus_pkg::n_ports]
);

    logic [dbus_pkg::n_ports-1:0]     pend;
    logic [dbus_pkg::n_ports-1:0]     port_we;
    logic [dbus_pkg::n_ports-1:0]     grant;
    dbus_pkg::region_t                port_region [dbus_pkg::n_ports];
    dbus_pkg::bus_addr_u              port_addr [dbus_pkg::n_ports];
    logic [dbus_pkg::data_w-1:0]      port_wdata [dbus_pkg::n_ports];
    logic [dbus_pkg::strb_w-1:0]      port_wstrb [dbus_pkg::n_ports];
    logic                             resp_valid;
    logic [dbus_pkg::data_w-1:0]      resp_data;
    logic                             dmem_en;
    logic                             dmem_we;
    logic [dbus_pkg::dmem_addr_w-1:0] dmem_idx;
    logic [dbus_pkg::data_w-1:0]      dmem_wdata;
    logic [dbus_pkg::strb_w-1:0]      dmem_wstrb;
    logic [dbus_pkg::data_w-1:0]      dmem_rdata;
    logic                             perf_en;
    logic                             perf_we;
    logic [3:0]                       perf_off;
    logic [1:0]                       perf_ctrl;
    logic [dbus_pkg::data_w-1:0]      perf_rdata;

    for (genvar p = 0; p < dbus_pkg::n_ports; p++) begin : g_port
        dbus_port u_port (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .req_i        (req_i[p]),
            .we_i         (we_i[p]),
            .addr_i       (addr_i[p]),
            .wdata_i      (wdata_i[p]),
            .wstrb_i      (wstrb_i[p]),
            .ack_o        (ack_o[p]),
            .rdata_o      (rdata_o[p]),
            .pend_o       (pend[p]),
            .region_o     (port_region[p]),
            .addr_o       (port_addr[p]),
            .we_o         (port_we[p]),
            .wdata_o      (port_wdata[p]),
            .wstrb_o      (port_wstrb[p]),
            .grant_i      (grant[p]),
            .resp_valid_i (resp_valid),   // shared, qualified by grant
            .resp_data_i  (resp_data)
        );
    end

    dbus_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .pend_i       (pend),
        .region_i     (port_region),
        .addr_i       (port_addr),
        .we_i         (port_we),
        .wdata_i      (port_wdata),
        .wstrb_i      (port_wstrb),
        .grant_o      (grant),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .dmem_en_o    (dmem_en),
        .dmem_we_o    (dmem_we),
        .dmem_idx_o   (dmem_idx),
        .dmem_wdata_o (dmem_wdata),
        .dmem_wstrb_o (dmem_wstrb),
        .dmem_rdata_i (dmem_rdata),
        .perf_en_o    (perf_en),
        .perf_we_o    (perf_we),
        .perf_off_o   (perf_off),
        .perf_ctrl_o  (perf_ctrl),
        .perf_rdata_i (perf_rdata)
    );

    dmem_ram u_dmem (
        .clk_i   (clk_i),
        .en_i    (dmem_en),
        .we_i    (dmem_we),
        .idx_i   (dmem_idx),
        .wdata_i (dmem_wdata),
        .wstrb_i (dmem_wstrb),
        .rdata_o (dmem_rdata)
    );

    perf_counter u_perf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .en_i    (perf_en),
        .we_i    (perf_we),
        .off_i   (perf_off),
        .ctrl_i  (perf_ctrl),
        .rdata_o (perf_rdata)
    );

endmodule

// ==== dbus/dbus_arbiter.sv ====
//////////////////////////////
// round-robin grant of one pending port at a time
// and steering of its access to memory or counter
//////////////////////////////

`timescale 1ns/100ps

module dbus_arbiter (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic [dbus_pkg::n_ports-1:0]       pend_i,
    input  dbus_pkg::region_t                  region_i [dbus_pkg::n_ports],
    input  dbus_pkg::bus_addr_u                addr_i [dbus_pkg::n_ports],
    input  logic [dbus_pkg::n_ports-1:0]       we_i,
    input  logic [dbus_pkg::data_w-1:0]        wdata_i [dbus_pkg::n_ports],
    input  logic [dbus_pkg::strb_w-1:0]        wstrb_i [dbus_pkg::n_ports],
    output logic [dbus_pkg::n_ports-1:0]       grant_o,
    output logic                               resp_valid_o,
    output logic [dbus_pkg::data_w-1:0]        resp_data_o,
    output logic                               dmem_en_o,
    output logic                               dmem_we_o,
    output logic [dbus_pkg::dmem_addr_w-1:0]   dmem_idx_o,
    output logic [dbus_pkg::data_w-1:0]        dmem_wdata_o,
    output logic [dbus_pkg::strb_w-1:0]        dmem_wstrb_o,
    input  logic [dbus_pkg::data_w-1:0]        dmem_rdata_i,
    output logic                               perf_en_o,
    output logic                               perf_we_o,
    output logic [3:0]                         perf_off_o,
    output logic [1:0]                         perf_ctrl_o,
    input  logic [dbus_pkg::data_w-1:0]        perf_rdata_i
);

    dbus_pkg::port_idx_t           rr_ptr_q;   // first port to look at
    dbus_pkg::port_idx_t           gnt_idx_q;
    logic [dbus_pkg::n_ports-1:0]  grant_q;
    logic                          resp_vld_q;
    dbus_pkg::port_idx_t           pick_idx;
    logic [dbus_pkg::n_ports-1:0]  pick_oh;
    logic                          pick_vld;
    logic                          access;     // grant cycle, target enabled
    dbus_pkg::region_t             sel_region;
    dbus_pkg::bus_addr_u           sel_addr;

    always_comb begin : pick
        int cand;
        pick_vld = 1'b0;
        pick_idx = rr_ptr_q;
        pick_oh  = '0;
        for (int k = 0; k < dbus_pkg::n_ports; k++) begin
            cand = (int'(rr_ptr_q) + k) % dbus_pkg::n_ports;
            if (!pick_vld && pend_i[cand]) begin
                pick_vld      = 1'b1;
                pick_idx      = dbus_pkg::port_idx_t'(cand);
                pick_oh[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            grant_q    <= '0;
            gnt_idx_q  <= '0;
            resp_vld_q <= 1'b0;
            rr_ptr_q   <= '0;
        end else if (resp_vld_q) begin
            grant_q    <= '0;  // access done, free for the next one
            resp_vld_q <= 1'b0;
            rr_ptr_q   <= dbus_pkg::port_idx_t'((int'(gnt_idx_q) + 1) % dbus_pkg::n_ports);
        end else if (access) begin
            resp_vld_q <= 1'b1;
        end else if (pick_vld) begin
            grant_q   <= pick_oh;
            gnt_idx_q <= pick_idx;
        end
    end

    assign access     = (|grant_q) && !resp_vld_q;
    assign sel_region = region_i[gnt_idx_q];
    assign sel_addr   = addr_i[gnt_idx_q];

    assign dmem_en_o    = access && (sel_region == dbus_pkg::region_dmem);
    assign dmem_we_o    = we_i[gnt_idx_q];
    assign dmem_idx_o   = sel_addr.dmem.idx;
    assign dmem_wdata_o = wdata_i[gnt_idx_q];
    assign dmem_wstrb_o = wstrb_i[gnt_idx_q];

    assign perf_en_o   = access && (sel_region == dbus_pkg::region_perf);
    assign perf_we_o   = we_i[gnt_idx_q];
    assign perf_off_o  = sel_addr.perf.off;
    assign perf_ctrl_o = wdata_i[gnt_idx_q][1:0];

    // region still valid here, grant is held through the response
    always_comb begin
        case (sel_region)
            dbus_pkg::region_dmem: resp_data_o = dmem_rdata_i;
            dbus_pkg::region_perf: resp_data_o = perf_rdata_i;
            default:               resp_data_o = '0;  // unmapped reads as zero
        endcase
    end

    assign grant_o      = grant_q;
    assign resp_valid_o = resp_vld_q;

    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant_o));

endmodule

// ==== dbus/dbus_port.sv ====
//////////////////////////////
// one requester port: takes a four-phase request,
// queues it for the arbiter and acks the result
//////////////////////////////

`timescale 1ns/100ps

module dbus_port (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // requester side
    input  logic                          req_i,
    input  logic                          we_i,
    input  logic [dbus_pkg::addr_w-1:0]   addr_i,
    input  logic [dbus_pkg::data_w-1:0]   wdata_i,
    input  logic [dbus_pkg::strb_w-1:0]   wstrb_i,
    output logic                          ack_o,
    output logic [dbus_pkg::data_w-1:0]   rdata_o,
    // arbiter side
    output logic                          pend_o,
    output dbus_pkg::region_t             region_o,
    output dbus_pkg::bus_addr_u           addr_o,
    output logic                          we_o,
    output logic [dbus_pkg::data_w-1:0]   wdata_o,
    output logic [dbus_pkg::strb_w-1:0]   wstrb_o,
    input  logic                          grant_i,
    input  logic                          resp_valid_i,
    input  logic [dbus_pkg::data_w-1:0]   resp_data_i
);

    logic                        capt_q;  // fields latched, pend next
    logic                        pend_q;
    logic                        wait_q;  // granted, waiting on response
    logic                        ack_q;
    logic                        idle;
    logic                        resp_take;
    dbus_pkg::region_t           region_d;
    dbus_pkg::region_t           region_q;
    dbus_pkg::bus_addr_u         addr_q;
    logic                        we_q;
    logic [dbus_pkg::data_w-1:0] wdata_q;
    logic [dbus_pkg::strb_w-1:0] wstrb_q;
    logic [dbus_pkg::data_w-1:0] rdata_q;

    assign idle      = !(capt_q || pend_q || wait_q || ack_q);
    assign resp_take = wait_q && grant_i && resp_valid_i;  // our grant is still recorded

    // dmem wins when bit 28 and bit 30 are both set
    always_comb begin
        if (addr_i[28]) begin
            region_d = dbus_pkg::region_dmem;
        end else if (addr_i[30] && !addr_i[12]) begin
            region_d = dbus_pkg::region_perf;
        end else begin
            region_d = dbus_pkg::region_none;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            capt_q <= 1'b0;
            pend_q <= 1'b0;
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            capt_q <= idle && req_i;
            if (capt_q) begin
                pend_q <= 1'b1;
            end else if (pend_q && grant_i) begin
                pend_q <= 1'b0;
            end
            if (pend_q && grant_i) begin
                wait_q <= 1'b1;
            end else if (resp_take) begin
                wait_q <= 1'b0;
            end
            if (resp_take) begin
                ack_q <= 1'b1;
            end else if (ack_q && !req_i) begin
                ack_q <= 1'b0;  // fourth phase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (idle && req_i) begin
            region_q <= region_d;
            addr_q   <= addr_i;
            we_q     <= we_i;
            wdata_q  <= wdata_i;
            wstrb_q  <= wstrb_i;
        end
        if (resp_take) begin
            rdata_q <= resp_data_i;
        end
    end

    assign ack_o    = ack_q;
    assign rdata_o  = rdata_q;
    assign pend_o   = pend_q;
    assign region_o = region_q;
    assign addr_o   = addr_q;
    assign we_o     = we_q;
    assign wdata_o  = wdata_q;
    assign wstrb_o  = wstrb_q;

    // ack is set at the edge where req was still up
    a_ack_in_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

    // requester holds its fields until ack, so the copy must match them
    a_fields_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pend_o |-> (addr_o == addr_i) && (we_o == we_i) && (region_o == region_d)
                   && (wdata_o == wdata_i) && (wstrb_o == wstrb_i));

endmodule

// ==== logic/perf_counter.sv ====
//////////////////////////////
// 64-bit cycle counter, control at offset 0,
// either half read back one cycle after enable
//////////////////////////////

`timescale 1ns/100ps

module perf_counter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic                        we_i,
    input  logic [3:0]                  off_i,
    input  logic [1:0]                  ctrl_i,
    output logic [dbus_pkg::data_w-1:0] rdata_o
);

    logic [1:0]                  ctrl_q;
    logic [63:0]                 count_q;
    logic [dbus_pkg::data_w-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= dbus_pkg::perf_ctrl_clear;
            count_q <= '0;
        end else begin
            if (en_i && we_i && (off_i == dbus_pkg::perf_ctrl_off)) begin
                ctrl_q <= ctrl_i;
            end
            case (ctrl_q)
                dbus_pkg::perf_ctrl_clear: count_q <= '0;
                dbus_pkg::perf_ctrl_run:   count_q <= count_q + 64'd1;
                default:                   count_q <= count_q;  // hold codes
            endcase
        end
    end

    // low half only at its own offset, high half otherwise
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            if (off_i == dbus_pkg::perf_low_off) begin
                rdata_q <= count_q[31:0];
            end else begin
                rdata_q <= count_q[63:32];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== logic/dmem_ram.sv ====
//////////////////////////////
// single-port data memory, byte strobed writes,
// read data one cycle after enable
//////////////////////////////

`timescale 1ns/100ps

module dmem_ram (
    input  logic                             clk_i,
    input  logic                             en_i,
    input  logic                             we_i,
    input  logic [dbus_pkg::dmem_addr_w-1:0] idx_i,
    input  logic [dbus_pkg::data_w-1:0]      wdata_i,
    input  logic [dbus_pkg::strb_w-1:0]      wstrb_i,
    output logic [dbus_pkg::data_w-1:0]      rdata_o
);

    logic [dbus_pkg::data_w-1:0] mem [dbus_pkg::dmem_entries];
    logic [dbus_pkg::data_w-1:0] rdata_q;

    // memory comes up cleared
    initial begin
        for (int i = 0; i < dbus_pkg::dmem_entries; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < dbus_pkg::strb_w; b++) begin
                    if (wstrb_i[b]) begin
                        mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];  // strobed bytes only
                    end
                end
            end else begin
                rdata_q <= mem[idx_i];
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== common/dbus_pkg.sv ====
//////////////////////////////
// widths, region codes and address views shared by
// the two-port data bus and its targets
//////////////////////////////

package dbus_pkg;

    // requester side
    localparam int n_ports = 2;
    typedef logic [$clog2(n_ports)-1:0] port_idx_t;

    // bus word
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;  // one strobe per byte

    // data memory geometry
    localparam int dmem_entries = 1024;
    localparam int dmem_addr_w  = 10;

    // decoded target of a request
    // bit 28 picks the data memory
    // bit 30 with bit 12 clear picks the counter
    typedef enum logic [1:0] {
        region_dmem,
        region_perf,
        region_none
    } region_t;

    // one bus address seen two ways
    typedef union packed {
        struct packed {
            logic [19:0]            hi;
            logic [dmem_addr_w-1:0] idx;  // word index
            logic [1:0]             ofs;  // byte in word
        } dmem;
        struct packed {
            logic [27:0] hi;
            logic [3:0]  off;  // counter register
        } perf;
    } bus_addr_u;

    // counter register offsets
    localparam logic [3:0] perf_ctrl_off = 4'h0;  // write ctrl, read high half
    localparam logic [3:0] perf_low_off  = 4'h4;  // read low half

    // counter control codes
    localparam logic [1:0] perf_ctrl_clear = 2'd0;  // count held at zero
    localparam logic [1:0] perf_ctrl_run   = 2'd1;  // +1 every cycle
    localparam logic [1:0] perf_ctrl_hold  = 2'd2;  // 2 and 3 both freeze

endpackage
